//--- design/video_mode_pkg.sv
package video_mode_pkg;

	//////////////////////////////////////////////////////////////
	// Widths and basic types
	//////////////////////////////////////////////////////////////
	typedef logic [10:0] coord_t;      // Pixel or line position
	typedef logic [3:0]  mode_sel_t;   // Switch code
	typedef logic [7:0]  clk_ratio_t;  // M or D, stored minus one

	typedef struct packed {
		clk_ratio_t mult;  // Clock generator M
		clk_ratio_t div;   // Clock generator D
	} pclk_ratio_t;

	// Terminal counts, all relative to pixel/line zero
	typedef struct packed {
		coord_t hsblnk;    // Last active pixel
		coord_t hssync;
		coord_t hesync;
		coord_t heblnk;    // Line total minus one
		coord_t vsblnk;
		coord_t vssync;
		coord_t vesync;
		coord_t veblnk;    // Frame total minus one
		logic   polarity;  // 1 = negative sync
	} raster_timing_t;

	typedef enum logic [1:0] {
		WAIT_SWITCH,
		PROGRAM,
		SETTLE,
		RUN
	} mode_state_t;

	// Mode switch codes
	localparam mode_sel_t MODE_VGA      = 4'b0000;
	localparam mode_sel_t MODE_SVGA     = 4'b0001;
	localparam mode_sel_t MODE_XGA      = 4'b0011;
	localparam mode_sel_t MODE_HDTV720P = 4'b0010;
	localparam mode_sel_t MODE_SXGA     = 4'b1000;
	localparam mode_sel_t MODE_CAMERA   = 4'b1001;

	//////////////////////////////////////////////////////////////
	// Porch tables
	//////////////////////////////////////////////////////////////
	typedef struct packed {
		coord_t active;
		coord_t front;
		coord_t sync_w;
		coord_t back;
	} porch_t;

	localparam porch_t H_VGA      = '{active: 11'd640,  front: 11'd16,  sync_w: 11'd96,  back: 11'd48};
	localparam porch_t V_VGA      = '{active: 11'd480,  front: 11'd11,  sync_w: 11'd2,   back: 11'd31};
	localparam porch_t H_SVGA     = '{active: 11'd800,  front: 11'd40,  sync_w: 11'd128, back: 11'd88};
	localparam porch_t V_SVGA     = '{active: 11'd600,  front: 11'd1,   sync_w: 11'd4,   back: 11'd23};
	localparam porch_t H_XGA      = '{active: 11'd1024, front: 11'd24,  sync_w: 11'd136, back: 11'd160};
	localparam porch_t V_XGA      = '{active: 11'd768,  front: 11'd3,   sync_w: 11'd6,   back: 11'd29};
	localparam porch_t H_SXGA     = '{active: 11'd1280, front: 11'd48,  sync_w: 11'd112, back: 11'd248};
	localparam porch_t V_SXGA     = '{active: 11'd1024, front: 11'd1,   sync_w: 11'd3,   back: 11'd38};
	localparam porch_t H_CAMERA   = '{active: 11'd1280, front: 11'd110, sync_w: 11'd39,  back: 11'd220};
	localparam porch_t V_CAMERA   = '{active: 11'd720,  front: 11'd4,   sync_w: 11'd4,   back: 11'd22};
	localparam porch_t H_HDTV720P = '{active: 11'd1280, front: 11'd110, sync_w: 11'd40,  back: 11'd220};
	localparam porch_t V_HDTV720P = '{active: 11'd720,  front: 11'd5,   sync_w: 11'd5,   back: 11'd20};

	localparam logic NEG_SYNC = 1'b1;
	localparam logic POS_SYNC = 1'b0;

	//////////////////////////////////////////////////////////////
	// Control timing
	//////////////////////////////////////////////////////////////
	localparam int DEBOUNCE_CYCLES = 16;  // Switch code must hold this long
	localparam int SETTLE_CYCLES   = 64;  // Restart hold after prog strobe

	typedef logic [$clog2(DEBOUNCE_CYCLES)-1:0]  deb_cnt_t;
	typedef logic [$clog2(SETTLE_CYCLES+1)-1:0] settle_cnt_t;

	localparam deb_cnt_t    DEBOUNCE_LAST = deb_cnt_t'(DEBOUNCE_CYCLES - 2);
	localparam settle_cnt_t SETTLE_LOAD   = settle_cnt_t'(SETTLE_CYCLES);
	localparam logic [1:0]  OUT_LATENCY   = 2'd3;  // Restart to de, in cycles

	// Porches to terminal counts
	function automatic raster_timing_t make_timing(porch_t h, porch_t v, logic pol);
		raster_timing_t t;
		t.hsblnk   = h.active - 11'd1;
		t.hssync   = t.hsblnk + h.front;
		t.hesync   = t.hssync + h.sync_w;
		t.heblnk   = t.hesync + h.back;
		t.vsblnk   = v.active - 11'd1;
		t.vssync   = t.vsblnk + v.front;
		t.vesync   = t.vssync + v.sync_w;
		t.veblnk   = t.vesync + v.back;
		t.polarity = pol;
		return t;
	endfunction

	function automatic raster_timing_t mode_timing(mode_sel_t m);
		case (m)
			MODE_VGA:      return make_timing(H_VGA, V_VGA, NEG_SYNC);
			MODE_SVGA:     return make_timing(H_SVGA, V_SVGA, POS_SYNC);
			MODE_XGA:      return make_timing(H_XGA, V_XGA, NEG_SYNC);
			MODE_SXGA:     return make_timing(H_SXGA, V_SXGA, POS_SYNC);
			MODE_CAMERA:   return make_timing(H_CAMERA, V_CAMERA, POS_SYNC);
			MODE_HDTV720P: return make_timing(H_HDTV720P, V_HDTV720P, POS_SYNC);
			default:       return make_timing(H_HDTV720P, V_HDTV720P, POS_SYNC);  // Unknown -> 720p
		endcase
	endfunction

	// Pixel clock M/D pairs, minus one
	function automatic pclk_ratio_t mode_ratio(mode_sel_t m);
		case (m)
			MODE_VGA:    return '{mult: 8'd2 - 8'd1, div: 8'd4 - 8'd1};      // 25 MHz
			MODE_SVGA:   return '{mult: 8'd4 - 8'd1, div: 8'd5 - 8'd1};      // 40 MHz
			MODE_XGA:    return '{mult: 8'd13 - 8'd1, div: 8'd10 - 8'd1};    // 65 MHz
			MODE_SXGA:   return '{mult: 8'd54 - 8'd1, div: 8'd25 - 8'd1};    // 108 MHz
			MODE_CAMERA: return '{mult: 8'd135 - 8'd1, div: 8'd91 - 8'd1};
			default:     return '{mult: 8'd248 - 8'd1, div: 8'd167 - 8'd1};  // 74.25 MHz
		endcase
	endfunction

endpackage

//--- design/mode_switch_sync.sv
`timescale 1ns/1ps

module mode_switch_sync (
	input  logic                      clk50m_bufg,
	input  logic                      serdes_rst,
	input  video_mode_pkg::mode_sel_t sw,
	output video_mode_pkg::mode_sel_t mode,
	output logic                      new_mode
);

	video_mode_pkg::mode_sel_t sw_meta;     // First sync flop
	video_mode_pkg::mode_sel_t sw_sync;     // Second sync flop
	video_mode_pkg::mode_sel_t cand;        // Previous synced value
	video_mode_pkg::deb_cnt_t  stable_cnt;  // Cycles without change
	logic                      accepted;    // A code was taken since reset
	logic                      stable_hit;

	// Held long enough, fires once per stable run
	assign stable_hit = (sw_sync == cand) && (stable_cnt == video_mode_pkg::DEBOUNCE_LAST);

	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			sw_meta    <= '0;
			sw_sync    <= '0;
			cand       <= '0;
			stable_cnt <= '0;
			accepted   <= 1'b0;
			mode       <= '0;
			new_mode   <= 1'b0;
		end else begin
			sw_meta  <= sw;
			sw_sync  <= sw_meta;
			cand     <= sw_sync;
			new_mode <= 1'b0;

			if (sw_sync != cand) begin
				stable_cnt <= '0;  // Bounce, start over
			end else if (stable_cnt <= video_mode_pkg::DEBOUNCE_LAST) begin
				stable_cnt <= stable_cnt + 1'b1;  // Stops one past the hit
			end

			// Only a code that differs from the last one counts,
			// except for the very first after reset
			if (stable_hit && (!accepted || (cand != mode))) begin
				mode     <= cand;
				accepted <= 1'b1;
				new_mode <= 1'b1;
			end
		end
	end

endmodule

//--- design/settle_timer.sv
`timescale 1ns/1ps

module settle_timer (
	input  logic clk50m_bufg,
	input  logic serdes_rst,
	input  logic start,
	output logic done
);

	video_mode_pkg::settle_cnt_t cnt;  // Zero when idle

	//////////////////////////////////////////////////////////////
	// Load on start, count down, one-cycle done at the bottom
	//////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			cnt  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				cnt <= video_mode_pkg::SETTLE_LOAD;  // Restart wins over count
			end else if (cnt != '0) begin
				cnt  <= cnt - 1'b1;
				done <= (cnt == video_mode_pkg::settle_cnt_t'(1));  // Last step
			end
		end
	end

endmodule

//--- design/mode_sequencer.sv
`timescale 1ns/1ps

module mode_sequencer (
	input  logic                           clk50m_bufg,
	input  logic                           serdes_rst,
	input  video_mode_pkg::mode_sel_t      mode,
	input  logic                           new_mode,
	input  logic                           settle_done,
	output logic                           settle_start,
	output logic                           prog_go,
	output video_mode_pkg::pclk_ratio_t    pclk_ratio,
	output video_mode_pkg::raster_timing_t timing,
	output logic                           mode_ready,
	output logic                           restart
);

	video_mode_pkg::mode_state_t state;
	logic [1:0] drain_cnt;  // Output pipe still flushing the old mode

	assign settle_start = (state == video_mode_pkg::PROGRAM);  // Timer starts with the strobe

	//////////////////////////////////////////////////////////////
	// Mode FSM
	//////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			state      <= video_mode_pkg::WAIT_SWITCH;
			prog_go    <= 1'b0;
			mode_ready <= 1'b0;
			restart    <= 1'b1;  // Raster idle until first mode
			timing     <= '0;    // Syncs rest low with polarity 0
			drain_cnt  <= '0;
		end else begin
			prog_go <= 1'b0;

			// mode_ready follows de down once the pipe has emptied
			if (drain_cnt != 2'd0) begin
				drain_cnt <= drain_cnt - 2'd1;
				if (drain_cnt == 2'd1)
					mode_ready <= 1'b0;
			end

			if (new_mode) begin
				state   <= video_mode_pkg::PROGRAM;
				prog_go <= 1'b1;
				restart <= 1'b1;
				timing  <= video_mode_pkg::mode_timing(mode);
				if (mode_ready)
					drain_cnt <= video_mode_pkg::OUT_LATENCY;
			end else begin
				case (state)
					video_mode_pkg::PROGRAM: state <= video_mode_pkg::SETTLE;
					video_mode_pkg::SETTLE: begin
						if (settle_done) begin  // Clock assumed re-locked
							state      <= video_mode_pkg::RUN;
							restart    <= 1'b0;
							mode_ready <= 1'b1;
						end
					end
					default: state <= state;  // WAIT_SWITCH and RUN wait for a switch
				endcase
			end
		end
	end

	// Ratio loads together with the strobe
	always_ff @(posedge clk50m_bufg) begin
		if (new_mode)
			pclk_ratio <= video_mode_pkg::mode_ratio(mode);
	end

endmodule

//--- design/raster_counter.sv
`timescale 1ns/1ps

module raster_counter (
	input  logic                           clk50m_bufg,
	input  logic                           serdes_rst,
	input  logic                           restart,
	input  video_mode_pkg::raster_timing_t timing,
	output logic                           hblnk,
	output logic                           hsync,
	output logic                           vblnk,
	output logic                           vsync
);

	video_mode_pkg::coord_t hcnt;  // Pixel in line
	video_mode_pkg::coord_t vcnt;  // Line in frame
	logic line_end;
	logic frame_end;

	assign line_end  = (hcnt == timing.heblnk);
	assign frame_end = (vcnt == timing.veblnk);

	//////////////////////////////////////////////////////////////
	// H/V counters
	//////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (restart) begin
			hcnt <= '0;  // Parked on pixel zero
			vcnt <= '0;
		end else if (line_end) begin
			hcnt <= '0;
			vcnt <= frame_end ? '0 : vcnt + 1'b1;  // Step once per line
		end else begin
			hcnt <= hcnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////
	// Blank and sync decode, one cycle behind the counters
	//////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			hblnk <= 1'b1;
			vblnk <= 1'b1;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else if (restart) begin
			hblnk <= 1'b1;  // Keep de off while the clock changes
			vblnk <= 1'b1;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			hblnk <= (hcnt > timing.hsblnk);
			vblnk <= (vcnt > timing.vsblnk);
			hsync <= (hcnt > timing.hssync) && (hcnt <= timing.hesync);  // sync_w pixels
			vsync <= (vcnt > timing.vssync) && (vcnt <= timing.vesync);  // Whole lines
		end
	end

endmodule

//--- design/sync_output.sv
`timescale 1ns/1ps

module sync_output (
	input  logic clk50m_bufg,
	input  logic serdes_rst,
	input  logic polarity,
	input  logic hblnk,
	input  logic vblnk,
	input  logic hsync_int,
	input  logic vsync_int,
	output logic hsync,
	output logic vsync,
	output logic de
);

	logic active;    // Inside both active windows
	logic hsync_q;
	logic vsync_q;
	logic active_q;

	assign active = !hblnk && !vblnk;

	// Two stages for all three so they stay lined up
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			hsync_q  <= 1'b0;
			vsync_q  <= 1'b0;
			active_q <= 1'b0;
			hsync    <= 1'b0;
			vsync    <= 1'b0;
			de       <= 1'b0;
		end else begin
			hsync_q  <= hsync_int ^ polarity;  // Negative sync inverts
			vsync_q  <= vsync_int ^ polarity;
			active_q <= active;
			hsync    <= hsync_q;
			vsync    <= vsync_q;
			de       <= active_q;
		end
	end

endmodule

//--- design/video_mode_top.sv
`timescale 1ns/1ps

module video_mode_top (
	input  logic                        clk50m_bufg,
	input  logic                        serdes_rst,
	input  video_mode_pkg::mode_sel_t   sw,
	output video_mode_pkg::pclk_ratio_t pclk_ratio,
	output logic                        prog_go,
	output logic                        mode_ready,
	output logic                        hsync,
	output logic                        vsync,
	output logic                        de
);

	video_mode_pkg::mode_sel_t      mode;
	video_mode_pkg::raster_timing_t timing;
	logic new_mode;
	logic settle_start, settle_done;
	logic restart;
	logic hblnk, vblnk;
	logic hsync_int, vsync_int;  // Active high, before polarity

	//////////////////////////////////////////////////////////////
	// Mode select and clock request
	//////////////////////////////////////////////////////////////
	mode_switch_sync switch_i (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.sw          (sw),
		.mode        (mode),
		.new_mode    (new_mode)
	);

	settle_timer settle_i (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.start       (settle_start),
		.done        (settle_done)
	);

	mode_sequencer seq_i (
		.clk50m_bufg  (clk50m_bufg),
		.serdes_rst   (serdes_rst),
		.mode         (mode),
		.new_mode     (new_mode),
		.settle_done  (settle_done),
		.settle_start (settle_start),
		.prog_go      (prog_go),
		.pclk_ratio   (pclk_ratio),
		.timing       (timing),
		.mode_ready   (mode_ready),
		.restart      (restart)
	);

	//////////////////////////////////////////////////////////////
	// Raster and output stage
	//////////////////////////////////////////////////////////////
	raster_counter raster_i (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.restart     (restart),
		.timing      (timing),
		.hblnk       (hblnk),
		.hsync       (hsync_int),
		.vblnk       (vblnk),
		.vsync       (vsync_int)
	);

	sync_output out_i (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.polarity    (timing.polarity),
		.hblnk       (hblnk),
		.vblnk       (vblnk),
		.hsync_int   (hsync_int),
		.vsync_int   (vsync_int),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de)
	);

endmodule

//--- verification/video_mode_assert.sv
`timescale 1ns/1ps

module video_mode_assert (
	input logic clk50m_bufg,
	input logic serdes_rst,
	input logic prog_go,
	input logic mode_ready,
	input logic hsync,
	input logic vsync,
	input logic de,
	input logic polarity
);

	////////////////////////////////////////////////////////////
	// Output protocol
	////////////////////////////////////////////////////////////
	prog_go_single: assert property (@(posedge clk50m_bufg) disable iff (serdes_rst)
		prog_go |=> !prog_go)
		else $error("prog_go held longer than one cycle");

	de_needs_ready: assert property (@(posedge clk50m_bufg) disable iff (serdes_rst)
		de |-> mode_ready)
		else $error("de high while mode_ready low");

	// Output stage is two cycles behind the polarity bit
	de_outside_sync: assert property (@(posedge clk50m_bufg) disable iff (serdes_rst)
		de |-> !(hsync ^ $past(polarity, 2)) && !(vsync ^ $past(polarity, 2)))
		else $error("de high during an active sync");

endmodule

bind video_mode_top video_mode_assert assert_i (
	.clk50m_bufg (clk50m_bufg),
	.serdes_rst  (serdes_rst),
	.prog_go     (prog_go),
	.mode_ready  (mode_ready),
	.hsync       (hsync),
	.vsync       (vsync),
	.de          (de),
	.polarity    (timing.polarity)
);

//--- verification/video_mode_tb.sv
`timescale 1ns/1ps

module video_mode_tb;

	typedef struct packed {
		logic [3:0] sw;
		int mult;
		int div;
		int line_total;
		int h_active;
		int h_sync;
		int frame_lines;
		int v_active;
		int v_sync;
		logic pol;
	} golden_t;

	localparam int SEL_H  = 0;  // Probe selectors
	localparam int SEL_V  = 1;
	localparam int SEL_DE = 2;

	logic clk50m_bufg;
	logic serdes_rst;
	video_mode_pkg::mode_sel_t   sw;
	video_mode_pkg::pclk_ratio_t pclk_ratio;
	logic prog_go, mode_ready, hsync, vsync, de;

	golden_t golden[8];
	int      n_modes = 0;
	logic    golden_loaded = 1'b0;
	int      errors = 0;
	int      cycle = 0;
	int      seed = 32'hb8a1;

	video_mode_top dut_i (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.sw          (sw),
		.pclk_ratio  (pclk_ratio),
		.prog_go     (prog_go),
		.mode_ready  (mode_ready),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de)
	);

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg;  // 50 MHz
	end

	always @(posedge clk50m_bufg) cycle <= cycle + 1;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	task automatic report_mismatch(input string msg);
		errors++;
		$display("error at %0t ns: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1, "stopping at first mismatch");
	endtask

	// Negative sync is active low
	function automatic logic probe(input int sel, input logic pol);
		if (sel == SEL_H)
			return hsync ^ pol;
		else if (sel == SEL_V)
			return vsync ^ pol;
		return de;
	endfunction

	task automatic wait_rise(input int sel, input logic pol);
		logic prev;
		prev = probe(sel, pol);
		@(negedge clk50m_bufg);
		while (prev || !probe(sel, pol)) begin
			prev = probe(sel, pol);
			@(negedge clk50m_bufg);
		end
	endtask

	task automatic run_length(input int sel, input logic pol, output int n);
		n = 0;
		while (probe(sel, pol)) begin
			n++;
			@(negedge clk50m_bufg);
		end
	endtask

	task automatic set_switch(input video_mode_pkg::mode_sel_t code);
		@(posedge clk50m_bufg);
		#1 sw = code;
	endtask

	// One prog_go with the golden pair, then mode_ready
	task automatic check_request(input golden_t g, input logic first,
			input video_mode_pkg::pclk_ratio_t old_ratio);
		int prog_cnt;
		logic saw_low;
		video_mode_pkg::pclk_ratio_t cap;
		prog_cnt = 0;
		saw_low  = first;
		cap      = '0;
		while (!(saw_low && prog_cnt > 0 && mode_ready)) begin
			@(negedge clk50m_bufg);
			if (prog_go) begin
				prog_cnt++;
				cap = pclk_ratio;
			end
			if (!mode_ready)
				saw_low = 1'b1;
		end
		assert (prog_cnt == 1)
			else report_mismatch($sformatf("%0d prog_go pulses, expected 1", prog_cnt));
		assert (cap.mult == 8'(g.mult - 1) && cap.div == 8'(g.div - 1))
			else report_mismatch($sformatf("ratio %0d/%0d, expected %0d/%0d",
				cap.mult + 1, cap.div + 1, g.mult, g.div));
		if (!first) begin
			assert (cap != old_ratio)
				else report_mismatch("pclk_ratio kept the old mode value");
		end
	endtask

	task automatic check_raster(input golden_t g);
		int t0, w, runs;
		logic done;
		// Line timing from hsync and de
		wait_rise(SEL_H, g.pol);
		t0 = cycle;
		run_length(SEL_H, g.pol, w);
		assert (w == g.h_sync)
			else report_mismatch($sformatf("hsync width %0d, expected %0d", w, g.h_sync));
		wait_rise(SEL_H, g.pol);
		assert (cycle - t0 == g.line_total)
			else report_mismatch($sformatf("line total %0d, expected %0d",
				cycle - t0, g.line_total));
		wait_rise(SEL_DE, 1'b0);
		run_length(SEL_DE, 1'b0, w);
		assert (w == g.h_active)
			else report_mismatch($sformatf("de run %0d, expected %0d", w, g.h_active));
		// Frame timing from vsync and de runs
		wait_rise(SEL_V, g.pol);
		run_length(SEL_V, g.pol, w);
		assert (w % g.line_total == 0 && w / g.line_total == g.v_sync)
			else report_mismatch($sformatf("vsync width %0d cycles, expected %0d lines",
				w, g.v_sync));
		runs = 0;
		done = 1'b0;
		while (!done) begin
			if (de)
				runs++;
			while (de)
				@(negedge clk50m_bufg);  // Skip rest of the run
			if (probe(SEL_V, g.pol))
				done = 1'b1;
			else
				@(negedge clk50m_bufg);
		end
		assert (runs == g.v_active)
			else report_mismatch($sformatf("%0d de runs per frame, expected %0d",
				runs, g.v_active));
	endtask

	////////////////////////////////////////////////////////////
	// Golden file and watchdog
	////////////////////////////////////////////////////////////
	task automatic load_golden();
		int fd, cnt, sw_v, m, d, lt, ha, hs, fl, va, vs, pl;
		string line;
		fd = $fopen("verification/video_mode_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden file");
			$display("Some tests failed");
			$fatal(1, "no stimulus");
		end
		while (!$feof(fd) && n_modes < 8) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line.substr(0, 0) == "#")
				continue;  // Column header
			cnt = $sscanf(line, "%h %d %d %d %d %d %d %d %d %d",
				sw_v, m, d, lt, ha, hs, fl, va, vs, pl);
			if (cnt == 10) begin
				golden[n_modes] = '{sw: 4'(sw_v), mult: m, div: d, line_total: lt,
					h_active: ha, h_sync: hs, frame_lines: fl, v_active: va,
					v_sync: vs, pol: pl[0]};
				n_modes++;
			end
		end
		$fclose(fd);
	endtask

	initial begin
		longint max_frame;
		wait (golden_loaded);
		max_frame = 0;
		for (int i = 0; i < n_modes; i++)
			if (longint'(golden[i].line_total) * golden[i].frame_lines > max_frame)
				max_frame = longint'(golden[i].line_total) * golden[i].frame_lines;
		// Three largest frames per mode plus slack
		#((3 * max_frame * n_modes + 20000) * 20);
		$display("timeout: the DUT did not reach the expected outputs in time");
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		video_mode_pkg::pclk_ratio_t old_ratio;
		video_mode_pkg::mode_sel_t   keep, bad;
		int g_len;
		serdes_rst = 1'b1;
		sw         = '0;
		old_ratio  = '0;
		load_golden();
		golden_loaded = 1'b1;
		assert (n_modes >= 2)
			else report_mismatch("golden file holds fewer than two modes");
		sw = golden[0].sw;
		repeat (16) @(posedge clk50m_bufg);
		#1 serdes_rst = 1'b0;

		for (int i = 0; i < n_modes; i++) begin
			if (i > 0) begin
				wait_rise(SEL_V, golden[i-1].pol);
				repeat (5) wait_rise(SEL_DE, 1'b0);  // Mid-frame
				set_switch(golden[i].sw);
			end
			check_request(golden[i], i == 0, old_ratio);
			check_raster(golden[i]);
			old_ratio = pclk_ratio;
		end

		// Short glitches must be filtered
		keep = golden[n_modes-1].sw;
		bad  = golden[0].sw;
		for (int k = 0; k < 3; k++) begin
			g_len = 1 + ($unsigned($random(seed)) % (video_mode_pkg::DEBOUNCE_CYCLES - 1));
			set_switch(bad);
			repeat (g_len) @(posedge clk50m_bufg);
			#1 sw = keep;
			repeat (4 * video_mode_pkg::DEBOUNCE_CYCLES) begin
				@(negedge clk50m_bufg);
				assert (!prog_go && mode_ready)
					else report_mismatch($sformatf("glitch of %0d cycles was taken", g_len));
			end
		end

		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- verification/video_mode_golden.txt
# sw(hex) mult div line_total h_active h_sync frame_lines v_active v_sync polarity
# mult/div as real values, polarity 1 means negative sync
0 2 4 800 640 96 524 480 2 1
1 4 5 1056 800 128 628 600 4 0

//--- build.f
design/video_mode_pkg.sv
design/mode_switch_sync.sv
design/settle_timer.sv
design/mode_sequencer.sv
design/raster_counter.sv
design/sync_output.sv
design/video_mode_top.sv
verification/video_mode_assert.sv
verification/video_mode_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide from the simulation log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module video_mode_tb \
	-Mdir obj_dir -o video_mode_sim > build.log 2>&1 \
	&& ./obj_dir/video_mode_sim > sim.log 2>&1 \
	|| { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0
